// ==== hdl/trace_config.svh ====
// Trace unit configuration
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// ---------------------------------------------------------------------------
// sizes
// ---------------------------------------------------------------------------
`define TRACE_WIDTH      32  // sample and output word width, >= counter width.
`define TRACE_FIFO_DEPTH 8   // fifo entries, power of two.
`define TRACE_CNT_WIDTH  16  // overflow loss counter width.

`endif

// ==== hdl/trace_pkg.sv ====
// Trace unit types
package trace_pkg;

  // -------------------------------------------------------------------------
  // control state machine
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // tracing off, pipeline empty.
    ST_RUN   = 2'd1,  // samples accepted.
    ST_DRAIN = 2'd2   // disabled, flushing what is left.
  } trace_state_e;

  // -------------------------------------------------------------------------
  // output packet kind
  // -------------------------------------------------------------------------
  typedef enum logic {
    PKT_SAMPLE   = 1'b0,  // raw trace sample.
    PKT_OVERFLOW = 1'b1   // count of lost samples.
  } trace_kind_e;

endpackage

// ==== hdl/trace_ctrl.sv ====
// Trace enable and drain control
`timescale 1ns/100ps

module trace_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic enable,        // level from software.
  input  logic sample_valid,  // raw strobe from the source.
  input  logic fifo_empty,
  input  logic ov_pending,    // sampler still holds an overflow record.
  input  logic out_valid,     // packetizer output register occupied.
  output logic gated_valid,
  output logic busy
);

  // -------------------------------------------------------------------------
  // state
  // -------------------------------------------------------------------------
  trace_pkg::trace_state_e state;       // current state.
  trace_pkg::trace_state_e state_nxt;   // next state.
  logic                    enable_q;    // registered enable.
  logic                    drained;     // nothing left anywhere.

  assign drained = fifo_empty & ~ov_pending & ~out_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable_q <= 1'b0;
      state    <= trace_pkg::ST_IDLE;
    end else begin
      enable_q <= enable;
      state    <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;  // hold by default.
    case (state)
      trace_pkg::ST_IDLE: begin
        if (enable_q) state_nxt = trace_pkg::ST_RUN;
      end
      trace_pkg::ST_RUN: begin
        if (!enable_q) state_nxt = trace_pkg::ST_DRAIN;
      end
      trace_pkg::ST_DRAIN: begin
        // wait for the whole pipe to empty before going idle
        if (drained) state_nxt = trace_pkg::ST_IDLE;
      end
      default: state_nxt = trace_pkg::ST_IDLE;
    endcase
  end

  // -------------------------------------------------------------------------
  // outputs
  // -------------------------------------------------------------------------
  assign gated_valid = sample_valid & (state == trace_pkg::ST_RUN);  // run only.
  assign busy        = (state != trace_pkg::ST_IDLE);                // till idle.

endmodule

// ==== hdl/trace_sample.sv ====
// Trace sampler with loss counting
`timescale 1ns/100ps
`include "trace_config.svh"

module trace_sample #(
  parameter int WIDTH = `TRACE_WIDTH
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] sample_data,
  input  logic             sample_valid,
  output logic [WIDTH-1:0] fifo_data,
  output logic             fifo_overflow,
  output logic             fifo_valid,
  input  logic             fifo_ready
);

  localparam int CW = `TRACE_CNT_WIDTH;  // loss counter width.

  // -------------------------------------------------------------------------
  // loss counter
  // -------------------------------------------------------------------------
  logic [CW-1:0] ov_counter;    // samples lost since last record.
  logic          passthrough;   // no pending loss.
  logic          ov_increment;  // sample dropped this cycle.
  logic          ov_saturate;   // counter at its ceiling.
  logic          ov_complete;   // record accepted, nothing new.
  logic          ov_again;      // record accepted, sample lost meanwhile.

  assign passthrough  = (ov_counter == '0);
  assign ov_increment = sample_valid & ~fifo_ready;
  assign ov_saturate  = &ov_counter;
  assign ov_complete  = fifo_overflow & fifo_ready & ~sample_valid;
  assign ov_again     = fifo_overflow & fifo_ready & sample_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ov_counter <= '0;
    end else if (ov_complete) begin
      ov_counter <= '0;                 // back to passthrough.
    end else if (ov_again) begin
      ov_counter <= CW'(1);             // the new sample is the first loss.
    end else if (ov_increment && !ov_saturate) begin
      ov_counter <= ov_counter + 1'b1;  // sticks at all ones.
    end
  end

  // -------------------------------------------------------------------------
  // fifo side
  // -------------------------------------------------------------------------
  assign fifo_data[CW-1:0] = passthrough ? sample_data[CW-1:0] : ov_counter;

  generate
    if (WIDTH > CW) begin : g_upper
      assign fifo_data[WIDTH-1:CW] = sample_data[WIDTH-1:CW];  // junk on overflow.
    end
  endgenerate

  assign fifo_overflow = ~passthrough;
  assign fifo_valid    = passthrough ? sample_valid : 1'b1;  // record held till taken.

endmodule

// ==== hdl/trace_fifo.sv ====
// Synchronous trace FIFO
`timescale 1ns/100ps

module trace_fifo #(
  parameter int WIDTH = 33,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_en,
  output logic             full,
  output logic [WIDTH-1:0] rd_data,
  input  logic             rd_en,
  output logic             empty
);

  localparam int AW = $clog2(DEPTH);  // index bits, depth is a power of two.

  // -------------------------------------------------------------------------
  // storage and pointers
  // -------------------------------------------------------------------------
  logic [WIDTH-1:0] mem [DEPTH];  // entry array.
  logic [AW:0]      wr_ptr;       // msb is the wrap bit.
  logic [AW:0]      rd_ptr;
  logic             do_wr;        // qualified write.
  logic             do_rd;        // qualified read.

  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // same index, different lap means full
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps naturally.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;  // no reset on the array.
    end
  end

  // -------------------------------------------------------------------------
  // read port
  // -------------------------------------------------------------------------
  // head entry is always presented; pop just advances the pointer
  assign rd_data = mem[rd_ptr[AW-1:0]];

endmodule

// ==== hdl/trace_packetizer.sv ====
// Trace packetizer and output register
`timescale 1ns/100ps
`include "trace_config.svh"

module trace_packetizer (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`TRACE_WIDTH:0]     fifo_data,   // {overflow flag, word}.
  input  logic                      fifo_empty,
  output logic                      fifo_pop,
  output logic [`TRACE_WIDTH-1:0]   out_data,
  output trace_pkg::trace_kind_e    out_kind,
  output logic                      out_valid,
  input  logic                      out_ready
);

  localparam int W  = `TRACE_WIDTH;
  localparam int CW = `TRACE_CNT_WIDTH;

  // keeps only the count field of an overflow word
  localparam logic [W-1:0] CNT_MASK = {W{1'b1}} >> (W - CW);

  // -------------------------------------------------------------------------
  // entry decode
  // -------------------------------------------------------------------------
  logic         is_ov;     // entry is an overflow record.
  logic [W-1:0] entry;     // raw word from the fifo.
  logic         reg_free;  // output register can take a new word.

  assign is_ov    = fifo_data[W];
  assign entry    = fifo_data[W-1:0];
  assign reg_free = ~out_valid | out_ready;
  assign fifo_pop = reg_free & ~fifo_empty;

  // -------------------------------------------------------------------------
  // output register
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (fifo_pop) begin
      out_valid <= 1'b1;          // new word loaded.
    end else if (out_ready) begin
      out_valid <= 1'b0;          // taken, nothing behind it.
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      if (is_ov) begin
        out_kind <= trace_pkg::PKT_OVERFLOW;
        out_data <= entry & CNT_MASK;  // drop stale sample bits.
      end else begin
        out_kind <= trace_pkg::PKT_SAMPLE;
        out_data <= entry;
      end
    end
  end

endmodule

// ==== hdl/trace_unit.sv ====
// Trace unit top level
`timescale 1ns/100ps
`include "trace_config.svh"

module trace_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    enable,
  input  logic [`TRACE_WIDTH-1:0] sample_data,
  input  logic                    sample_valid,
  output logic [`TRACE_WIDTH-1:0] out_data,
  output trace_pkg::trace_kind_e  out_kind,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic                    busy
);

  // -------------------------------------------------------------------------
  // internal nets
  // -------------------------------------------------------------------------
  logic                    gated_valid;    // strobe while running.
  logic [`TRACE_WIDTH-1:0] fifo_data;      // sampler word.
  logic                    fifo_overflow;  // sampler word is a record.
  logic                    fifo_valid;
  logic                    fifo_ready;
  logic                    fifo_wr;        // write handshake.
  logic                    fifo_full;
  logic                    fifo_empty;
  logic                    fifo_pop;
  logic [`TRACE_WIDTH:0]   fifo_rd_data;   // flag travels with the word.

  assign fifo_ready = ~fifo_full;
  assign fifo_wr    = fifo_valid & fifo_ready;

  // -------------------------------------------------------------------------
  // instances
  // -------------------------------------------------------------------------
  trace_ctrl u_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .sample_valid (sample_valid),
    .fifo_empty   (fifo_empty),
    .ov_pending   (fifo_overflow),  // record not yet written.
    .out_valid    (out_valid),
    .gated_valid  (gated_valid),
    .busy         (busy)
  );

  trace_sample #(
    .WIDTH (`TRACE_WIDTH)
  ) u_sample (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample_data   (sample_data),
    .sample_valid  (gated_valid),
    .fifo_data     (fifo_data),
    .fifo_overflow (fifo_overflow),
    .fifo_valid    (fifo_valid),
    .fifo_ready    (fifo_ready)
  );

  trace_fifo #(
    .WIDTH (`TRACE_WIDTH + 1),
    .DEPTH (`TRACE_FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_data ({fifo_overflow, fifo_data}),
    .wr_en   (fifo_wr),
    .full    (fifo_full),
    .rd_data (fifo_rd_data),
    .rd_en   (fifo_pop),
    .empty   (fifo_empty)
  );

  trace_packetizer u_pkt (
    .clk        (clk),
    .arst_n     (arst_n),
    .fifo_data  (fifo_rd_data),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .out_data   (out_data),
    .out_kind   (out_kind),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

// ==== dv/trace_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module trace_clkgen #(
  parameter int PERIOD_NS    = 100,  // clock period.
  parameter int RESET_CYCLES = 8     // rising edges under reset.
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;                           // asserted from time zero.
    #(PERIOD_NS * RESET_CYCLES) arst_n = 1'b1;  // released on a falling edge.
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== dv/trace_unit_chk.sv ====
// Trace unit assertion checker
`timescale 1ns/100ps
`include "trace_config.svh"

module trace_unit_chk (
  input logic                    clk,
  input logic                    arst_n,
  input logic [`TRACE_WIDTH-1:0] out_data,
  input trace_pkg::trace_kind_e  out_kind,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic                    busy,
  input logic                    fifo_wr,    // fifo write handshake.
  input logic                    fifo_full,
  input logic                    fifo_pop,   // fifo read handshake.
  input logic                    fifo_empty,
  input trace_pkg::trace_state_e state       // controller state.
);

  localparam int CW    = `TRACE_CNT_WIDTH;
  localparam int DEPTH = `TRACE_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------
  a_hold_stall: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_kind))
    else $error("output word changed while stalled");

  a_ov_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && (out_kind == trace_pkg::PKT_OVERFLOW) |-> (out_data[CW-1:0] != '0))
    else $error("overflow packet with a zero count");

  // --------------------------------------------------------------------------
  // fifo and control
  // --------------------------------------------------------------------------
  logic [AW:0] occ;  // entries held, counted from the handshakes.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      occ <= '0;
    end else if (fifo_wr && !fifo_pop) begin
      occ <= occ + 1'b1;
    end else if (fifo_pop && !fifo_wr) begin
      occ <= occ - 1'b1;
    end
  end

  a_no_wr_full: assert property (@(posedge clk) disable iff (!arst_n)
    (occ == DEPTH) |-> fifo_full && !fifo_wr)
    else $error("fifo written while full");

  a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    (state == trace_pkg::ST_IDLE) |-> !busy && fifo_empty && !out_valid)
    else $error("busy or pipeline active in idle");

endmodule

// ==== dv/trace_unit_tb.sv ====
// Trace unit testbench
`timescale 1ns/100ps
`include "trace_config.svh"

module trace_unit_tb;

  localparam int W         = `TRACE_WIDTH;
  localparam int CW        = `TRACE_CNT_WIDTH;
  localparam int DRIVE_DLY = 10;           // ns after the rising edge.
  localparam int WAIT_MAX  = 300;          // cycles allowed for busy to move.
  localparam int T4_STALL  = 65535 + 200;  // enough losses to saturate.
  localparam int WATCHDOG  = 20 + 200 + 430 + T4_STALL + 80 + 150 + 10 * WAIT_MAX + 2000;
  localparam logic [W-1:0] CNT_MASK = (W'(1) << CW) - 1;  // count field.

  logic                   clk;
  logic                   arst_n;
  logic                   enable;
  logic [W-1:0]           sample_data;
  logic                   sample_valid;
  logic [W-1:0]           out_data;
  trace_pkg::trace_kind_e out_kind;
  logic                   out_valid;
  logic                   out_ready;
  logic                   busy;

  // scoreboard state
  int           errors;
  int           tests_run;
  int           tests_bad;
  logic [31:0]  rng;          // lcg state.
  logic [W-1:0] next_seq;     // number of the next sample sent.
  logic [W-1:0] last_seq;     // last sample number seen at the output.
  logic [W-1:0] lost_sum;     // overflow counts since that sample.
  logic [W-1:0] resume_seq;   // first sample after a saturating stall.
  logic [W-1:0] first_seq;    // first number of the current run.
  logic [W-1:0] run_samples;  // sample packets in this run.
  logic [W-1:0] run_lost;     // overflow counts in this run.
  logic         sat_seen;     // saturated count pending.
  logic         sat_hit;      // saturated count ever seen.
  logic         loss_ok;      // overflow packets may appear.

  trace_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clkgen (.clk(clk), .arst_n(arst_n));

  trace_unit dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .enable       (enable),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .out_data     (out_data),
    .out_kind     (out_kind),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .busy         (busy)
  );

  bind trace_unit trace_unit_chk u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_data   (out_data),
    .out_kind   (out_kind),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .busy       (busy),
    .fifo_wr    (fifo_wr),
    .fifo_full  (fifo_full),
    .fifo_pop   (fifo_pop),
    .fifo_empty (fifo_empty),
    .state      (u_ctrl.state)
  );

  // --------------------------------------------------------------------------
  // reference and compare
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;  // lcg step.
    return rng;
  endfunction

  // a sample follows the last one plus the losses reported in between
  function automatic logic [W-1:0] expect_packet(
    input  trace_pkg::trace_kind_e obs_kind,
    input  logic [W-1:0]           obs_data,
    input  logic [W-1:0]           prev_seq,
    input  logic [W-1:0]           lost,
    output trace_pkg::trace_kind_e exp_kind
  );
    if (!loss_ok || obs_kind == trace_pkg::PKT_SAMPLE) begin
      exp_kind = trace_pkg::PKT_SAMPLE;
      return sat_seen ? resume_seq : prev_seq + lost + 1;  // true gap unknown once capped.
    end
    exp_kind = trace_pkg::PKT_OVERFLOW;
    return obs_data & CNT_MASK;  // upper bits must be clear.
  endfunction

  task automatic check_word(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_kind(input string name, input trace_pkg::trace_kind_e got,
                            input trace_pkg::trace_kind_e exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // one output transfer per rising edge with valid and ready high
  always @(negedge clk) begin : compare_outputs
    trace_pkg::trace_kind_e exp_kind;
    logic [W-1:0]           exp_word;
    logic [W-1:0]           count;
    if (arst_n && out_valid && out_ready) begin
      exp_word = expect_packet(out_kind, out_data, last_seq, lost_sum, exp_kind);
      check_kind("out_kind", out_kind, exp_kind);
      check_word("out_data", out_data, exp_word);
      count = out_data & CNT_MASK;
      if (out_kind == trace_pkg::PKT_OVERFLOW) begin
        if (last_seq + lost_sum + count >= next_seq) begin
          errors++;
          $display("overflow count %0d at %0t exceeds the samples sent", count, $time);
        end
        lost_sum = lost_sum + count;
        run_lost = run_lost + count;
        if (count == CNT_MASK) begin
          sat_seen = 1'b1;  // counter stuck at its ceiling.
          sat_hit  = 1'b1;
        end
      end else begin
        last_seq    = out_data;  // resync on the observed number.
        lost_sum    = '0;
        sat_seen    = 1'b0;
        run_samples = run_samples + 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic step(input logic strobe, input logic ready);
    @(posedge clk);
    #DRIVE_DLY;
    sample_valid = strobe;
    out_ready    = ready;
    if (strobe) begin
      sample_data = next_seq;  // running sequence number.
      next_seq    = next_seq + 1;
    end
  endtask

  task automatic start_run();
    int n;
    n           = 0;
    enable      = 1'b1;
    first_seq   = next_seq;
    run_samples = '0;
    run_lost    = '0;
    while (!busy && n < WAIT_MAX) begin
      step(1'b0, out_ready);
      n++;
    end
    if (!busy) begin
      errors++;
      $display("busy did not rise after enable, at %0t", $time);
    end
  endtask

  task automatic stop_run(input logic rand_ready, input logic exact);
    int          n;
    logic [31:0] r;
    n      = 0;
    enable = 1'b0;
    while (busy && n < WAIT_MAX) begin
      r = next_rand();
      step(1'b0, rand_ready ? r[22] : 1'b1);
      n++;
    end
    if (busy) begin
      errors++;
      $display("busy did not fall after disable, at %0t", $time);
    end
    if (exact) check_word("samples plus lost", run_samples + run_lost, next_seq - first_seq);
    repeat (4) begin
      step(1'b0, 1'b1);
      check_flag("out_valid", out_valid, 1'b0);  // nothing after busy falls.
    end
  endtask

  task automatic report_test(input int num, input string name, input int base);
    tests_run++;
    if (errors != base) tests_bad++;
    $display("test %0d %s: %s, %0d errors", num, name, (errors == base) ? "ok" : "bad",
             errors - base);
  endtask

  initial begin : run_tests
    int          base;
    logic [31:0] r;
    enable = 1'b0;
    sample_data = '0;
    sample_valid = 1'b0;
    out_ready = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    rng = 32'h29d9cf03;
    next_seq = 1;
    last_seq = '0;
    lost_sum = '0;
    resume_seq = '0;
    first_seq = 1;
    run_samples = '0;
    run_lost = '0;
    sat_seen = 1'b0;
    sat_hit = 1'b0;
    loss_ok = 1'b0;
    wait (arst_n === 1'b1);
    step(1'b0, 1'b0);

    // test 1, strobes ignored while disabled
    base = errors;
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("busy", busy, 1'b0);
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      sample_valid = 1'b1;
      sample_data  = W'(32'hbad00000 | i);  // not a sequence number.
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("busy", busy, 1'b0);
    end
    sample_valid = 1'b0;
    report_test(1, "idle while disabled", base);

    // test 2, no stall so no loss
    base = errors;
    start_run();
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      step(r[18] | r[25], 1'b1);
    end
    stop_run(1'b0, 1'b1);
    report_test(2, "samples in order", base);

    // test 3, fill the fifo then random back-pressure
    base    = errors;
    loss_ok = 1'b1;
    start_run();
    repeat (30) step(1'b1, 1'b0);
    for (int i = 0; i < 400; i++) begin
      r = next_rand();
      step(r[18] | r[25], r[21]);
    end
    stop_run(1'b0, 1'b1);
    report_test(3, "overflow accounting", base);

    // test 4, losses beyond the counter range
    base = errors;
    start_run();
    repeat (T4_STALL) step(1'b1, 1'b0);
    resume_seq = next_seq;
    repeat (30) step(1'b0, 1'b1);
    repeat (50) step(1'b1, 1'b1);
    check_flag("saturated count seen", sat_hit, 1'b1);
    stop_run(1'b0, 1'b0);
    report_test(4, "counter saturation", base);

    // test 5, drain after disable under random ready
    base = errors;
    start_run();
    for (int i = 0; i < 150; i++) begin
      r = next_rand();
      step(r[19], r[22]);
    end
    stop_run(1'b1, 1'b1);
    report_test(5, "drain and busy", base);

    $display("%0d tests, %0d with errors, %0d errors in total", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== trace_unit.f ====
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_ctrl.sv
hdl/trace_sample.sv
hdl/trace_fifo.sv
hdl/trace_packetizer.sv
hdl/trace_unit.sv
dv/trace_clkgen.sv
dv/trace_unit_chk.sv
dv/trace_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the trace unit

VERILATOR ?= verilator
TOP       ?= trace_unit_tb
FILELIST  ?= trace_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
